// ==== sim.f ====
+incdir+common
common/port_pkg.sv
common/flit_pkg.sv
common/flit_if.sv
hdl/input_stage.sv
arbiter/rr_arbiter.sv
arbiter/switch_allocator.sv
crossbar/output_stage.sv
hdl/router_core.sv
sim/tb_router_core.sv

// ==== Bender.yml ====
package:
  name: router_core

sources:
  - include_dirs:
      - common
    files:
      - common/port_pkg.sv
      - common/flit_pkg.sv
      - common/flit_if.sv
      - hdl/input_stage.sv
      - arbiter/rr_arbiter.sv
      - arbiter/switch_allocator.sv
      - crossbar/output_stage.sv
      - hdl/router_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_router_core.sv

// ==== sim/tb_router_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module tb_router_core;

        localparam int NP = `ROUTER_NUM_PORTS;
        localparam int DW = `ROUTER_DATA_W;

        localparam logic [2:0] to_n = 3'd0;
        localparam logic [2:0] to_s = 3'd1;
        localparam logic [2:0] to_w = 3'd2;
        localparam logic [2:0] to_e = 3'd3;
        localparam logic [2:0] to_l = 3'd4;

        // each table row holds new flits per input, hops, sink ready mask and cycles
        typedef struct packed {
                int              test;
                logic [NP-1:0]   valid;
                logic [3*NP-1:0] hops;
                logic [NP-1:0]   ready;
                int              hold;
        } step_t;

        typedef struct packed {
                logic [2:0]    hop;
                logic [DW-1:0] data;
        } src_flit_t;

        logic          clk;
        logic          reset_i;
        logic [NP-1:0] in_valid_i;
        logic [NP-1:0] in_ready_o;
        logic [2:0]    in_next_hop_i [NP];
        logic [DW-1:0] in_data_i [NP];
        logic [NP-1:0] out_valid_o;
        logic [NP-1:0] out_ready_i;
        logic [DW-1:0] out_data_o [NP];

        step_t         steps [$];
        src_flit_t     src_q [NP][$];
        logic [DW-1:0] exp_q [NP][$];
        string         test_name [1:5];

        // reference model state
        logic [NP-1:0] m_in_full;
        logic [2:0]    m_in_hop [NP];
        logic [DW-1:0] m_in_data [NP];
        logic [NP-1:0] m_out_full;
        int            m_ptr [NP];

        logic [31:0] seed;
        int          check_count;
        int          err_count;
        int          sent_count;
        int          recv_count;
        int          cycle_count;
        int          cycle_limit = 0;

        router_core i_router_core (
                .clk           (clk),
                .reset_i       (reset_i),
                .in_valid_i    (in_valid_i),
                .in_ready_o    (in_ready_o),
                .in_next_hop_i (in_next_hop_i),
                .in_data_i     (in_data_i),
                .out_valid_o   (out_valid_o),
                .out_ready_i   (out_ready_i),
                .out_data_o    (out_data_o)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        function automatic logic [31:0] next_random(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic logic [3*NP-1:0] pack_hops(input logic [2:0] n, input logic [2:0] s,
                                                      input logic [2:0] w, input logic [2:0] e,
                                                      input logic [2:0] l);
                return {l, e, w, s, n};
        endfunction

        function automatic logic all_empty();
                logic empty;

                empty = (m_in_full == '0) && (m_out_full == '0);
                for (int p = 0; p < NP; p++) begin
                        if (src_q[p].size() != 0 || exp_q[p].size() != 0) begin
                                empty = 1'b0;
                        end
                end
                return empty;
        endfunction

        task automatic add_step(input int test, input logic [NP-1:0] valid,
                                input logic [3*NP-1:0] hops, input logic [NP-1:0] ready,
                                input int hold);
                step_t st;

                st.test  = test;
                st.valid = valid;
                st.hops  = hops;
                st.ready = ready;
                st.hold  = hold;
                steps.push_back(st);
        endtask

        // drive on the falling edge, check, then advance the model per clock
        task automatic run_cycle(input logic [NP-1:0] rdy);
                logic [NP-1:0] drv_valid;
                logic [NP-1:0] gnt_in;
                logic [NP-1:0] exp_ready;
                logic [NP-1:0] acc;
                int            grant_src [NP];
                int            idx;

                @(negedge clk);
                for (int p = 0; p < NP; p++) begin
                        drv_valid[p]  = src_q[p].size() > 0;
                        in_valid_i[p] = drv_valid[p];
                        if (drv_valid[p]) begin
                                in_next_hop_i[p] = src_q[p][0].hop;
                                in_data_i[p]     = src_q[p][0].data;
                        end
                end
                out_ready_i = rdy;

                // winner-relative round robin into free outputs only
                gnt_in = '0;
                for (int o = 0; o < NP; o++) begin
                        grant_src[o] = -1;
                        if (!m_out_full[o] || rdy[o]) begin
                                for (int i = 0; i < NP; i++) begin
                                        idx = (m_ptr[o] + i) % NP;
                                        if (grant_src[o] < 0 && m_in_full[idx] &&
                                            m_in_hop[idx] == o) begin
                                                grant_src[o] = idx;
                                        end
                                end
                        end
                        if (grant_src[o] >= 0) begin
                                gnt_in[grant_src[o]] = 1'b1;
                        end
                end
                for (int p = 0; p < NP; p++) begin
                        exp_ready[p] = !m_in_full[p] || gnt_in[p];
                end

                #5;
                check_count++;
                if (in_ready_o !== exp_ready) begin
                        $display("** Error at %0t: in_ready_o expected %b got %b",
                                 $time, exp_ready, in_ready_o);
                        err_count++;
                end
                check_count++;
                if (out_valid_o !== m_out_full) begin
                        $display("** Error at %0t: out_valid_o expected %b got %b",
                                 $time, m_out_full, out_valid_o);
                        err_count++;
                end
                // a held output must keep showing the queue head
                for (int o = 0; o < NP; o++) begin
                        if (m_out_full[o]) begin
                                check_count++;
                                if (out_data_o[o] !== exp_q[o][0]) begin
                                        $display("** Error at %0t: out_data_o[%0d] expected %h got %h",
                                                 $time, o, exp_q[o][0], out_data_o[o]);
                                        err_count++;
                                end
                        end
                        if (out_valid_o[o] && rdy[o]) begin
                                recv_count++;
                        end
                end
                acc = drv_valid & exp_ready;

                @(posedge clk);
                for (int o = 0; o < NP; o++) begin
                        if (m_out_full[o] && rdy[o]) begin
                                void'(exp_q[o].pop_front());
                        end
                        if (grant_src[o] >= 0) begin
                                exp_q[o].push_back(m_in_data[grant_src[o]]);
                                m_ptr[o]      = (grant_src[o] + 1) % NP;
                                m_out_full[o] = 1'b1;
                        end else if (rdy[o]) begin
                                m_out_full[o] = 1'b0;
                        end
                end
                for (int p = 0; p < NP; p++) begin
                        if (acc[p]) begin
                                m_in_full[p] = 1'b1;
                                m_in_hop[p]  = src_q[p][0].hop;
                                m_in_data[p] = src_q[p][0].data;
                                void'(src_q[p].pop_front());
                        end else if (gnt_in[p]) begin
                                m_in_full[p] = 1'b0;
                        end
                end
        endtask

        initial begin : watchdog
                cycle_count = 0;
                wait (cycle_limit > 0);
                while (cycle_count < cycle_limit) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("run timed out after %0d cycles without draining", cycle_count);
                $display("CHECKS FAILED");
                $finish;
        end

        initial begin
                int        total_hold;
                int        test_checks;
                int        test_errors;
                src_flit_t f;

                reset_i     = 1'b1;
                in_valid_i  = '0;
                out_ready_i = '0;
                for (int p = 0; p < NP; p++) begin
                        in_next_hop_i[p] = '0;
                        in_data_i[p]     = '0;
                        m_in_hop[p]      = '0;
                        m_in_data[p]     = '0;
                        m_ptr[p]         = 0;
                end
                m_in_full   = '0;
                m_out_full  = '0;
                seed        = 32'haaa5;
                check_count = 0;
                err_count   = 0;
                sent_count  = 0;
                recv_count  = 0;
                test_checks = 0;
                test_errors = 0;

                test_name[1] = "reset state";
                test_name[2] = "single west to east";
                test_name[3] = "local contention";
                test_name[4] = "five disjoint routes";
                test_name[5] = "east back-pressure";

                add_step(1, 5'b00000, pack_hops(to_n, to_n, to_n, to_n, to_n), 5'b11111, 3);
                add_step(2, 5'b00100, pack_hops(to_n, to_n, to_e, to_n, to_n), 5'b11111, 5);
                add_step(3, 5'b01111, pack_hops(to_l, to_l, to_l, to_l, to_n), 5'b11111, 8);
                add_step(3, 5'b00011, pack_hops(to_l, to_l, to_l, to_l, to_n), 5'b11111, 6);
                // pointer now at west so this burst starts there
                add_step(3, 5'b01111, pack_hops(to_l, to_l, to_l, to_l, to_n), 5'b11111, 8);
                add_step(4, 5'b11111, pack_hops(to_s, to_n, to_e, to_l, to_w), 5'b11111, 5);
                add_step(5, 5'b00111, pack_hops(to_e, to_e, to_e, to_n, to_n), 5'b10111, 5);
                add_step(5, 5'b00110, pack_hops(to_e, to_e, to_e, to_n, to_n), 5'b10111, 5);
                add_step(5, 5'b00000, pack_hops(to_e, to_e, to_e, to_n, to_n), 5'b11111, 14);

                total_hold = 0;
                foreach (steps[s]) begin
                        total_hold += steps[s].hold;
                end
                cycle_limit = 8 * total_hold + 50;

                repeat (2) @(posedge clk);
                @(negedge clk);
                reset_i = 1'b0;

                for (int s = 0; s < steps.size(); s++) begin
                        if (s == 0 || steps[s].test != steps[s-1].test) begin
                                test_checks = check_count;
                                test_errors = err_count;
                        end
                        for (int p = 0; p < NP; p++) begin
                                if (steps[s].valid[p]) begin
                                        seed   = next_random(seed);
                                        f.hop  = steps[s].hops[3*p +: 3];
                                        f.data = seed[31:16];
                                        src_q[p].push_back(f);
                                        sent_count++;
                                end
                        end
                        repeat (steps[s].hold) run_cycle(steps[s].ready);
                        if (s == steps.size() - 1 || steps[s+1].test != steps[s].test) begin
                                $display("test %0d %s: %0d checks, %0d errors", steps[s].test,
                                         test_name[steps[s].test], check_count - test_checks,
                                         err_count - test_errors);
                        end
                end

                while (!all_empty()) begin
                        run_cycle('1);
                end
                if (recv_count != sent_count) begin
                        $display("flit count mismatch, %0d sent but %0d delivered",
                                 sent_count, recv_count);
                        err_count++;
                end

                $display("checks %0d, errors %0d, flits sent %0d, delivered %0d",
                         check_count, err_count, sent_count, recv_count);
                if (err_count == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== hdl/router_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module router_core (
        input  logic                         clk,
        input  logic                         reset_i,
        input  logic [`ROUTER_NUM_PORTS-1:0] in_valid_i,
        output logic [`ROUTER_NUM_PORTS-1:0] in_ready_o,
        input  logic [2:0]                   in_next_hop_i [`ROUTER_NUM_PORTS],
        input  logic [`ROUTER_DATA_W-1:0]    in_data_i [`ROUTER_NUM_PORTS],
        output logic [`ROUTER_NUM_PORTS-1:0] out_valid_o,
        input  logic [`ROUTER_NUM_PORTS-1:0] out_ready_i,
        output logic [`ROUTER_DATA_W-1:0]    out_data_o [`ROUTER_NUM_PORTS]
);

        import port_pkg::*;

        port_id_t      hop_id [`ROUTER_NUM_PORTS];
        grant_matrix_t grant;
        port_vec_t     out_free;

        // one head flit per input port
        flit_if head [`ROUTER_NUM_PORTS] ();

        // raw 3-bit codes onto the port enumeration
        for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_hop
                assign hop_id[p] = port_id_t'(in_next_hop_i[p]);
        end

        input_stage i_input_stage (
                .clk           (clk),
                .reset_i       (reset_i),
                .in_valid_i    (in_valid_i),
                .in_ready_o    (in_ready_o),
                .in_next_hop_i (hop_id),
                .in_data_i     (in_data_i),
                .head          (head)
        );

        switch_allocator i_switch_allocator (
                .clk        (clk),
                .reset_i    (reset_i),
                .head       (head),
                .out_free_i (out_free),
                .grant_o    (grant)
        );

        // grants land in the output registers on the same edge
        output_stage i_output_stage (
                .clk         (clk),
                .reset_i     (reset_i),
                .head        (head),
                .grant_i     (grant),
                .out_free_o  (out_free),
                .out_valid_o (out_valid_o),
                .out_ready_i (out_ready_i),
                .out_data_o  (out_data_o)
        );

endmodule

`default_nettype wire

// ==== crossbar/output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module output_stage (
        input  logic                    clk,
        input  logic                    reset_i,
        flit_if.xbar                    head [`ROUTER_NUM_PORTS],
        input  port_pkg::grant_matrix_t grant_i,
        output port_pkg::port_vec_t     out_free_o,
        output port_pkg::port_vec_t     out_valid_o,
        input  port_pkg::port_vec_t     out_ready_i,
        output flit_pkg::data_t         out_data_o [`ROUTER_NUM_PORTS]
);

        import port_pkg::*;
        import flit_pkg::*;

        data_t head_data [`ROUTER_NUM_PORTS];

        for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_in
                assign head_data[p] = head[p].data;
        end

        for (genvar o = 0; o < `ROUTER_NUM_PORTS; o++) begin : g_out
                port_vec_t sel;
                data_t     mux_data;
                logic      load;
                logic      valid_q;
                data_t     data_q;

                // select lines straight from the grant row
                assign sel = grant_i[o];

                // one-hot and-or mux
                always_comb begin
                        mux_data = '0;
                        for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                                if (sel[p]) begin
                                        mux_data = mux_data | head_data[p];
                                end
                        end
                end

                assign load          = |sel;
                assign out_free_o[o] = !valid_q || out_ready_i[o];

                always_ff @(posedge clk) begin
                        if (reset_i) begin
                                valid_q <= 1'b0;
                        end else if (load) begin
                                valid_q <= 1'b1;
                        end else if (out_ready_i[o]) begin
                                valid_q <= 1'b0;
                        end
                end

                // held stable while the sink stalls
                always_ff @(posedge clk) begin
                        if (load) begin
                                data_q <= mux_data;
                        end
                end

                assign out_valid_o[o] = valid_q;
                assign out_data_o[o]  = data_q;
        end

endmodule

`default_nettype wire

// ==== arbiter/switch_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module switch_allocator (
        input  logic                    clk,
        input  logic                    reset_i,
        flit_if.alloc                   head [`ROUTER_NUM_PORTS],
        input  port_pkg::port_vec_t     out_free_i,
        output port_pkg::grant_matrix_t grant_o
);

        import port_pkg::*;

        port_vec_t head_valid;
        port_id_t  head_hop [`ROUTER_NUM_PORTS];
        port_vec_t req [`ROUTER_NUM_PORTS];
        port_vec_t granted;

        for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_in
                assign head_valid[p] = head[p].valid;
                assign head_hop[p]   = head[p].next_hop;
                assign head[p].ready = granted[p];
        end

        // desire comparison, input p wants output o
        always_comb begin
                for (int o = 0; o < `ROUTER_NUM_PORTS; o++) begin
                        for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                                req[o][p] = head_valid[p] && (head_hop[p] == port_id_t'(o));
                        end
                end
        end

        // an input leaves when any output picked it
        always_comb begin
                granted = '0;
                for (int o = 0; o < `ROUTER_NUM_PORTS; o++) begin
                        granted = granted | grant_o[o];
                end
        end

        for (genvar o = 0; o < `ROUTER_NUM_PORTS; o++) begin : g_out
                rr_arbiter i_rr_arbiter (
                        .clk     (clk),
                        .reset_i (reset_i),
                        .req_i   (req[o]),
                        .en_i    (out_free_i[o]),
                        .grant_o (grant_o[o])
                );
        end

endmodule

`default_nettype wire

// ==== arbiter/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module rr_arbiter (
        input  logic                clk,
        input  logic                reset_i,
        input  port_pkg::port_vec_t req_i,
        input  logic                en_i,
        output port_pkg::port_vec_t grant_o
);

        import port_pkg::*;

        port_id_t ptr_q;
        port_id_t winner;
        logic     found;

        // first requester at or after the pointer, wrapping past local
        always_comb begin
                int unsigned idx;

                grant_o = '0;
                winner  = ptr_q;
                found   = 1'b0;
                for (int i = 0; i < `ROUTER_NUM_PORTS; i++) begin
                        idx = (int'(ptr_q) + i) % `ROUTER_NUM_PORTS;
                        if (!found && en_i && req_i[idx]) begin
                                grant_o[idx] = 1'b1;
                                winner       = port_id_t'(idx);
                                found        = 1'b1;
                        end
                end
        end

        // winner drops to lowest priority
        always_ff @(posedge clk) begin
                if (reset_i) begin
                        ptr_q <= port_north;
                end else if (found) begin
                        ptr_q <= port_id_t'((int'(winner) + 1) % `ROUTER_NUM_PORTS);
                end
        end

endmodule

`default_nettype wire

// ==== hdl/input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module input_stage (
        input  logic                clk,
        input  logic                reset_i,
        input  port_pkg::port_vec_t in_valid_i,
        output port_pkg::port_vec_t in_ready_o,
        input  port_pkg::port_id_t  in_next_hop_i [`ROUTER_NUM_PORTS],
        input  flit_pkg::data_t     in_data_i [`ROUTER_NUM_PORTS],
        flit_if.src                 head [`ROUTER_NUM_PORTS]
);

        import flit_pkg::*;

        for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_port
                logic  full_q;
                logic  load;
                flit_t flit_q;

                // room when empty, or when the head leaves this cycle
                assign in_ready_o[p] = !full_q || head[p].ready;
                assign load = in_valid_i[p] && in_ready_o[p];

                always_ff @(posedge clk) begin
                        if (reset_i) begin
                                full_q <= 1'b0;
                        end else if (load) begin
                                full_q <= 1'b1;
                        end else if (head[p].ready) begin
                                // head granted with nothing behind it
                                full_q <= 1'b0;
                        end
                end

                always_ff @(posedge clk) begin
                        if (load) begin
                                flit_q.next_hop <= in_next_hop_i[p];
                                flit_q.data     <= in_data_i[p];
                        end
                end

                assign head[p].valid    = full_q;
                assign head[p].next_hop = flit_q.next_hop;
                assign head[p].data     = flit_q.data;
        end

endmodule

`default_nettype wire

// ==== common/flit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// head flit of one input port, seen by allocator and crossbar
interface flit_if;
        import port_pkg::*;
        import flit_pkg::*;

        logic     valid;
        logic     ready;
        port_id_t next_hop;
        data_t    data;

        // input register side
        modport src (
                output valid,
                output next_hop,
                output data,
                input  ready
        );

        // ready here means the head is granted and leaves this cycle
        modport alloc (
                input  valid,
                input  next_hop,
                output ready
        );

        modport xbar (
                input data,
                input next_hop
        );

endinterface

`default_nettype wire

// ==== common/flit_pkg.sv ====
`default_nettype none

`include "router_macros.svh"

package flit_pkg;

        typedef logic [`ROUTER_DATA_W-1:0] data_t;

        // next hop code travels with the payload
        typedef struct packed {
                port_pkg::port_id_t next_hop;
                data_t              data;
        } flit_t;

endpackage

`default_nettype wire

// ==== common/port_pkg.sv ====
`default_nettype none

`include "router_macros.svh"

package port_pkg;

        // port codes, also the rotation order of the arbiters
        typedef enum logic [2:0] {
                port_north = 3'd0,
                port_south = 3'd1,
                port_west  = 3'd2,
                port_east  = 3'd3,
                port_local = 3'd4
        } port_id_t;

        // one bit per port, indexed by port_id_t
        typedef logic [`ROUTER_NUM_PORTS-1:0] port_vec_t;

        // indexed by output port, each entry one-hot in input ports or zero
        typedef port_vec_t [`ROUTER_NUM_PORTS-1:0] grant_matrix_t;

endpackage

`default_nettype wire

// ==== common/router_macros.svh ====
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// payload bits carried by every flit
`define ROUTER_DATA_W 16

// north, south, west, east and local
`define ROUTER_NUM_PORTS 5

`endif
